/* src.f */
hdl/ocpMasterPkg.sv
hdl/burstCfgIf.sv
hdl/burstSetup.sv
hdl/requestSequencer.sv
hdl/responseForwarder.sv
hdl/ocpMasterTop.sv
testbench/ocpMasterTb.sv

/* Makefile */
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -Wno-fatal
TOP       := ocpMasterTb
FILELIST  := src.f
OBJDIR    := obj_dir
SIM       := $(OBJDIR)/V$(TOP)
LOG       := sim.log
SOURCES   := $(shell grep -v '^+' $(FILELIST))

.PHONY: all run clean

all: run

# Rebuilt only when a source or the file list changes
$(SIM): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(OBJDIR) -o V$(TOP)

# Pass only when the log holds the pass line
run: $(SIM)
	./$(SIM) | tee $(LOG)
	@grep -q "^NO ERRORS$$" $(LOG)

clean:
	rm -rf $(OBJDIR) $(LOG)

/* testbench/ocpMasterTb.sv */
`timescale 1ns/1ps

module ocpMasterTb;
  import ocpMasterPkg::*;

  localparam int RunCycles = 3000;
  localparam int DrainTimeout = 100;
  localparam logic [31:0] LfsrTaps = 32'h80200003;

  logic Clk = 1'b0;
  logic reset;
  logic readRequest, writeRequest, SCmdAccept, SRespLast, streamReady;
  addrT address, MAddr;
  burstLenT burstLength, MBurstLength;
  burstSeqT burstSeq, MBurstSeq;
  byteEnT byteEnables, MByteEn;
  dataT writeData, MData, SData, streamData;
  ocpCmdT MCmd;
  ocpRespT SResp;
  logic MReqLast, MRespAccept, streamValid, streamLast, streamFail;

  // Request model
  ocpCmdT expCmd;
  addrT expAddr;
  burstLenT expCount, expLen;
  burstSeqT expSeq;
  byteEnT expBe;
  dataT expData;
  // Response model holds {fail, last, data} per word
  logic [DataWidth+1:0] respQ[$];

  logic [31:0] lfsrState = 32'd19;
  logic draining;
  int errorCount, checkCount, waitCount;
  int readBursts, writeBursts, bothSeen, forwarded, dropped;

  ocpMasterTop u_ocpMasterTop (.*);

  always #2 Clk = ~Clk;

  // Galois LFSR stepped once per bit
  function automatic logic [31:0] randBits(input int count);
    logic [31:0] result;
    logic outBit;
    result = '0;
    for (int i = 0; i < count; i++) begin
      outBit = lfsrState[0];
      lfsrState = lfsrState >> 1;
      if (outBit) lfsrState = lfsrState ^ LfsrTaps;
      result = {result[30:0], outBit};
    end
    return result;
  endfunction

  task checkValue(input string name, input logic [63:0] got, input logic [63:0] exp);
    checkCount++;
    if (got !== exp) begin
      errorCount++;
      $display("CHECK FAILED %s got 0x%0h expected 0x%0h at %0t", name, got, exp, $time);
    end
  endtask

  // Read wins, INCR steps by ByteCount, data taken at launch
  task updateRequestModel();
    if (expCmd == CmdIdle) begin
      if (readRequest || writeRequest) begin
        if (readRequest && writeRequest) bothSeen++;
        if (readRequest) readBursts++;
        else writeBursts++;
        expCmd = readRequest ? CmdRead : CmdWrite;
        expAddr = address;
        expLen = burstLength;
        expSeq = burstSeq;
        expBe = byteEnables;
        expCount = '0;
        expData = readRequest ? '0 : writeData;
      end
    end else if (SCmdAccept) begin
      if (expCount == expLen - 1'b1) begin
        expCmd = CmdIdle;
      end else begin
        expCount = expCount + 1'b1;
        if (expSeq == SeqIncr) expAddr = expAddr + addrT'(ByteCount);
        if (expCmd == CmdWrite) expData = writeData;
      end
    end
  endtask

  task updateResponseModel(input logic accept);
    // Held word leaves before the new one is queued
    if (respQ.size() != 0 && streamReady) void'(respQ.pop_front());
    if (accept && SResp != RespNull) begin
      if (SResp == RespDva || SResp == RespFail) begin
        respQ.push_back({SResp == RespFail, SRespLast, SData});
        forwarded++;
      end else begin
        dropped++;
      end
    end
  endtask

  task driveInputs(input logic accept);
    readRequest  <= !draining && randBits(2) == 0;
    writeRequest <= !draining && randBits(2) == 0;
    address      <= randBits(32);
    burstLength  <= burstLenT'(randBits(3) + 1);
    burstSeq     <= randBits(1) ? SeqStrm : SeqIncr;
    byteEnables  <= byteEnT'(randBits(4));
    writeData    <= randBits(32);
    SCmdAccept   <= draining || randBits(1);
    streamReady  <= draining || randBits(1);
    // Slave holds a response until it is accepted
    if (!(SResp != RespNull && !accept)) begin
      SResp     <= draining ? RespNull : ocpRespT'(randBits(2));
      SData     <= randBits(32);
      SRespLast <= 1'(randBits(1));
    end
  endtask

  // Inputs read here still hold the values of the cycle just ended
  task stepCycle();
    logic expAccept;
    logic expLast;
    @(posedge Clk);
    expAccept = (respQ.size() == 0) || streamReady;
    expLast = (expCmd != CmdIdle) && (expCount == expLen - 1'b1);
    checkValue("MCmd", MCmd, expCmd);
    checkValue("MReqLast", MReqLast, expLast);
    if (expCmd != CmdIdle) begin
      checkValue("MAddr", MAddr, expAddr);
      checkValue("MData", MData, expData);
      checkValue("MByteEn", MByteEn, expBe);
      checkValue("MBurstLength", MBurstLength, expLen);
      checkValue("MBurstSeq", MBurstSeq, expSeq);
    end
    checkValue("streamValid", streamValid, respQ.size() != 0);
    checkValue("MRespAccept", MRespAccept, expAccept);
    if (respQ.size() != 0) begin
      checkValue("streamData", streamData, respQ[0][DataWidth-1:0]);
      checkValue("streamLast", streamLast, respQ[0][DataWidth]);
      checkValue("streamFail", streamFail, respQ[0][DataWidth+1]);
    end
    updateRequestModel();
    updateResponseModel(expAccept);
    driveInputs(expAccept);
  endtask

  initial begin
    reset = 1'b1;
    readRequest = 1'b0;
    writeRequest = 1'b0;
    address = '0;
    burstLength = burstLenT'(1);
    burstSeq = SeqIncr;
    byteEnables = '0;
    writeData = '0;
    SCmdAccept = 1'b0;
    SResp = RespNull;
    SData = '0;
    SRespLast = 1'b0;
    streamReady = 1'b0;
    draining = 1'b0;
    expCmd = CmdIdle;
    expAddr = '0;
    expCount = '0;
    expLen = burstLenT'(1);
    expSeq = SeqIncr;
    expBe = '0;
    expData = '0;
    repeat (4) @(posedge Clk);
    reset <= 1'b0;
    // First step covers the idle state right after reset
    repeat (RunCycles) stepCycle();
    // Quiet bridge and slave, open stream, let everything settle
    draining = 1'b1;
    waitCount = 0;
    while ((expCmd != CmdIdle || respQ.size() != 0) && waitCount < DrainTimeout) begin
      stepCycle();
      waitCount++;
    end
    if (waitCount >= DrainTimeout) begin
      errorCount++;
      $display("Timeout while waiting for the last burst and stream word to finish");
    end
    if (readBursts == 0 || writeBursts == 0 || bothSeen == 0
        || forwarded == 0 || dropped == 0) begin
      errorCount++;
      $display("Random stimulus missed a read, write, tie, forwarded or dropped case");
    end
    $display("Checks %0d, errors %0d, bursts %0d/%0d, responses kept %0d dropped %0d",
      checkCount, errorCount, readBursts, writeBursts, forwarded, dropped);
    if (errorCount == 0) begin
      $display("NO ERRORS");
    end else begin
      $display("ERRORS FOUND");
    end
    $finish;
  end

endmodule

/* hdl/ocpMasterTop.sv */
`timescale 1ns/1ps

module ocpMasterTop (
  input  logic                   Clk,
  input  logic                   reset,

  // Bridge side
  input  logic                   readRequest,
  input  logic                   writeRequest,
  input  ocpMasterPkg::addrT     address,
  input  ocpMasterPkg::burstLenT burstLength,
  input  ocpMasterPkg::burstSeqT burstSeq,
  input  ocpMasterPkg::byteEnT   byteEnables,
  input  ocpMasterPkg::dataT     writeData,

  // OCP request group
  output ocpMasterPkg::ocpCmdT   MCmd,
  output ocpMasterPkg::addrT     MAddr,
  output ocpMasterPkg::dataT     MData,
  output ocpMasterPkg::byteEnT   MByteEn,
  output ocpMasterPkg::burstLenT MBurstLength,
  output ocpMasterPkg::burstSeqT MBurstSeq,
  output logic                   MReqLast,
  input  logic                   SCmdAccept,

  // OCP response group
  input  ocpMasterPkg::ocpRespT  SResp,
  input  ocpMasterPkg::dataT     SData,
  input  logic                   SRespLast,
  output logic                   MRespAccept,

  // Stream toward the FIFO
  output logic                   streamValid,
  output ocpMasterPkg::dataT     streamData,
  output logic                   streamLast,
  output logic                   streamFail,
  input  logic                   streamReady
);

  // Setup registers to sequencer link
  burstCfgIf cfgBus ();

  burstSetup u_burstSetup (
    .Clk           (Clk),
    .reset         (reset),
    .address       (address),
    .burstLengthIn (burstLength),
    .burstSeqIn    (burstSeq),
    .byteEnables   (byteEnables),
    .cfg           (cfgBus.setup)
  );

  requestSequencer u_requestSequencer (
    .Clk          (Clk),
    .reset        (reset),
    .readRequest  (readRequest),
    .writeRequest (writeRequest),
    .SCmdAccept   (SCmdAccept),
    .writeData    (writeData),
    .cfg          (cfgBus.sequencer),
    .MCmd         (MCmd),
    .MData        (MData),
    .MReqLast     (MReqLast)
  );

  // Request fields straight from the held burst state
  assign MAddr        = cfgBus.beatAddr;
  assign MByteEn      = cfgBus.byteEn;
  assign MBurstLength = cfgBus.burstLength;
  assign MBurstSeq    = cfgBus.burstSeq;

  // Response path is independent of the request side
  responseForwarder u_responseForwarder (
    .Clk         (Clk),
    .reset       (reset),
    .SRespLast   (SRespLast),
    .streamReady (streamReady),
    .SResp       (SResp),
    .SData       (SData),
    .MRespAccept (MRespAccept),
    .streamValid (streamValid),
    .streamLast  (streamLast),
    .streamFail  (streamFail),
    .streamData  (streamData)
  );

endmodule

/* hdl/responseForwarder.sv */
`timescale 1ns/1ps

module responseForwarder (
  input  logic                  Clk,
  input  logic                  reset,
  input  logic                  SRespLast,
  input  logic                  streamReady,
  input  ocpMasterPkg::ocpRespT SResp,
  input  ocpMasterPkg::dataT    SData,
  output logic                  MRespAccept,
  output logic                  streamValid,
  output logic                  streamLast,
  output logic                  streamFail,
  output ocpMasterPkg::dataT    streamData
);
  import ocpMasterPkg::*;

  // Response handed over at this edge
  logic respTaken;
  // Response worth forwarding
  logic respKeep;

  // Room when empty or when the held word leaves this cycle
  assign MRespAccept = !streamValid || streamReady;

  assign respTaken = MRespAccept && (SResp != RespNull);
  // ERR gets accepted but dropped
  assign respKeep = (SResp == RespDva) || (SResp == RespFail);

  // Occupancy of the holding register
  always_ff @(posedge Clk) begin
    if (reset) begin
      streamValid <= 1'b0;
    end else if (respTaken && respKeep) begin
      streamValid <= 1'b1;
    end else if (streamReady) begin
      streamValid <= 1'b0;
    end
  end

  // Held word
  always_ff @(posedge Clk) begin
    if (respTaken && respKeep) begin
      streamData <= SData;
      streamLast <= SRespLast;
      streamFail <= (SResp == RespFail);
    end
  end

  // Stalled word must not change under back-pressure
  assert property (@(posedge Clk) disable iff (reset)
    (streamValid && !streamReady) |=>
      (streamValid && $stable(streamData) && $stable(streamLast)
        && $stable(streamFail)));

endmodule

/* hdl/requestSequencer.sv */
`timescale 1ns/1ps

module requestSequencer (
  input  logic                 Clk,
  input  logic                 reset,
  input  logic                 readRequest,
  input  logic                 writeRequest,
  input  logic                 SCmdAccept,
  input  ocpMasterPkg::dataT   writeData,
  burstCfgIf.sequencer         cfg,
  output ocpMasterPkg::ocpCmdT MCmd,
  output ocpMasterPkg::dataT   MData,
  output logic                 MReqLast
);
  import ocpMasterPkg::*;

  // FSM state doubles as the MCmd code
  ocpCmdT state;

  // New burst only taken while idle
  assign cfg.load = (state == CmdIdle) && (readRequest || writeRequest);

  // Beat accepted by the slave
  assign cfg.advance = (state != CmdIdle) && SCmdAccept;

  // Request FSM
  always_ff @(posedge Clk) begin
    if (reset) begin
      state <= CmdIdle;
    end else begin
      case (state)
        CmdIdle: begin
          // Read wins when both arrive together
          if (readRequest) begin
            state <= CmdRead;
          end else if (writeRequest) begin
            state <= CmdWrite;
          end
        end
        default: begin
          // Back to idle once the last beat is taken
          if (cfg.advance && cfg.lastBeat) begin
            state <= CmdIdle;
          end
        end
      endcase
    end
  end

  // Write data sampled at each beat launch
  // Reads carry zero for the whole burst
  always_ff @(posedge Clk) begin
    if (cfg.load) begin
      MData <= readRequest ? '0 : writeData;
    end else if (cfg.advance && state == CmdWrite) begin
      MData <= writeData;
    end
  end

  assign MCmd = state;

  // Qualified so the flag stays low between bursts
  assign MReqLast = (state != CmdIdle) && cfg.lastBeat;

  // Waiting beat must hold its command, data and last flag
  assert property (@(posedge Clk) disable iff (reset)
    (MCmd != CmdIdle && !SCmdAccept) |=>
      ($stable(MCmd) && $stable(MData) && $stable(MReqLast)));

endmodule

/* hdl/burstSetup.sv */
`timescale 1ns/1ps

module burstSetup (
  input  logic                   Clk,
  input  logic                   reset,
  input  ocpMasterPkg::addrT     address,
  input  ocpMasterPkg::burstLenT burstLengthIn,
  input  ocpMasterPkg::burstSeqT burstSeqIn,
  input  ocpMasterPkg::byteEnT   byteEnables,
  burstCfgIf.setup               cfg
);
  import ocpMasterPkg::*;

  // Beats already accepted in the current burst
  burstLenT beatCount;

  // Beat counter
  // Cleared on load, bumped per accepted beat
  always_ff @(posedge Clk) begin
    if (reset) begin
      beatCount <= '0;
    end else if (cfg.load) begin
      beatCount <= '0;
    end else if (cfg.advance) begin
      beatCount <= beatCount + 1'b1;
    end
  end

  // Burst parameters held for the whole burst
  always_ff @(posedge Clk) begin
    if (cfg.load) begin
      cfg.byteEn      <= byteEnables;
      cfg.burstLength <= burstLengthIn;
      cfg.burstSeq    <= burstSeqIn;
    end
  end

  // Beat address
  // Start address on load, then step per beat for INCR only
  always_ff @(posedge Clk) begin
    if (cfg.load) begin
      cfg.beatAddr <= address;
    end else if (cfg.advance && cfg.burstSeq == SeqIncr) begin
      cfg.beatAddr <= cfg.beatAddr + addrT'(ByteCount);
    end
  end

  // Final beat when count reaches length minus one
  assign cfg.lastBeat = (beatCount == cfg.burstLength - 1'b1);

  // Bridge must never start a zero-length burst
  assert property (@(posedge Clk) disable iff (reset)
    cfg.load |-> burstLengthIn != '0);

  // Only INCR and STRM sequences are handled here
  assert property (@(posedge Clk) disable iff (reset)
    cfg.load |-> (burstSeqIn == SeqIncr || burstSeqIn == SeqStrm));

endmodule

/* hdl/burstCfgIf.sv */
`timescale 1ns/1ps

interface burstCfgIf;
  import ocpMasterPkg::*;

  // Strobes from the sequencer
  logic load;
  logic advance;

  // Current burst state from the setup registers
  addrT beatAddr;
  byteEnT byteEn;
  burstLenT burstLength;
  burstSeqT burstSeq;
  logic lastBeat;

  modport setup (
    input load, advance,
    output beatAddr, byteEn, burstLength, burstSeq, lastBeat
  );

  // Sequencer only needs the end-of-burst flag back
  modport sequencer (
    output load, advance,
    input lastBeat
  );

endinterface

/* hdl/ocpMasterPkg.sv */
package ocpMasterPkg;

  // Data path and address widths
  localparam int AddrWidth = 32;
  localparam int DataWidth = 32;

  // Bytes per data word
  // Also the address step of one INCR beat
  localparam int ByteCount = DataWidth / 8;

  // Burst length field as carried on MBurstLength
  localparam int BurstLenWidth = 10;

  typedef logic [AddrWidth-1:0] addrT;
  typedef logic [DataWidth-1:0] dataT;
  typedef logic [ByteCount-1:0] byteEnT;
  typedef logic [BurstLenWidth-1:0] burstLenT;

  // MCmd codes in use
  typedef enum logic [2:0] {
    CmdIdle  = 3'd0,
    CmdWrite = 3'd1,
    CmdRead  = 3'd2
  } ocpCmdT;

  // SResp codes
  typedef enum logic [1:0] {
    RespNull = 2'd0,
    RespDva  = 2'd1,
    RespFail = 2'd2,
    RespErr  = 2'd3
  } ocpRespT;

  // MBurstSeq codes
  // Only incrementing and streaming are supported
  typedef enum logic [2:0] {
    SeqIncr = 3'd0,
    SeqStrm = 3'd5
  } burstSeqT;

endpackage
